//--- sources.f
+incdir+common
common/btac_pkg.sv
logic/predictor_table.sv
logic/flush_fsm.sv
logic/index_counter.sv
btac/btac_ctrl.sv
btac/btac.sv
tb/tb_clock.sv
tb/btac_tb.sv

//--- tb/btac_tb.sv
`include "btac_consts.svh"

module btac_tb;

  localparam int flush_len    = 1 << `BTAC_INDEX_BITS;
  localparam int num_flushes  = 3;
  localparam int directed_ops = 120;
  localparam int random_ops   = 400;
  // Every flush and operation, with the idle gaps, fits twice over
  localparam int max_cycles = 2 * (num_flushes * flush_len + directed_ops + random_ops);

  logic                        clock;
  logic                        reset;
  logic                        clear;
  logic                        look_valid;
  logic [`BTAC_PC_BITS-1:0]    look_pc;
  logic                        upd_valid;
  logic [`BTAC_PC_BITS-1:0]    upd_pc;
  logic                        upd_taken;
  logic [`BTAC_PC_BITS-1:0]    upd_target;
  logic                        busy;
  logic                        pred_valid;
  logic                        pred_taken;
  logic [`BTAC_PC_BITS-1:0]    pred_target;
  logic                        pred_miss;
  logic [`BTAC_PC_BITS-1:0]    miss_addr;

  // Reference copy of both tables
  logic                        ref_valid  [0:flush_len-1];
  logic [`BTAC_PC_BITS-1:0]    ref_tag    [0:flush_len-1];
  logic [`BTAC_PC_BITS-1:0]    ref_target [0:flush_len-1];
  int                          ref_count  [0:flush_len-1];
  logic                        model_busy;
  logic [`BTAC_INDEX_BITS-1:0] model_index;

  logic                        exp_valid;
  logic                        exp_taken;
  logic [`BTAC_PC_BITS-1:0]    exp_target;
  logic                        exp_miss;
  logic                        exp_miss_check;
  logic [`BTAC_PC_BITS-1:0]    exp_miss_addr;

  int unsigned                 lcg_state;
  int                          cycle_count = 0;
  string                       test_name;

  tb_clock clock_gen (
    .clock (clock)
  );

  btac uut (
    .clock       (clock),
    .reset       (reset),
    .clear       (clear),
    .look_valid  (look_valid),
    .look_pc     (look_pc),
    .upd_valid   (upd_valid),
    .upd_pc      (upd_pc),
    .upd_taken   (upd_taken),
    .upd_target  (upd_target),
    .busy        (busy),
    .pred_valid  (pred_valid),
    .pred_taken  (pred_taken),
    .pred_target (pred_target),
    .pred_miss   (pred_miss),
    .miss_addr   (miss_addr)
  );

  task automatic value_mismatch(input string check, input logic [31:0] expected,
                                input logic [31:0] actual);
    $display("** Error [%s] %s: expected %h, actual %h", test_name, check, expected, actual);
    $display("*** FAILED ***");
    $fatal(1, "value mismatch");
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "run aborted");
  endtask

  function automatic logic [`BTAC_INDEX_BITS-1:0] index_of(input logic [`BTAC_PC_BITS-1:0] pc);
    return pc[`BTAC_INDEX_BITS:1];  // Halfword aligned index
  endfunction

  function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Eight PCs on distinct indices, 8 and 9 alias PCs 0 and 1 with another tag
  function automatic logic [`BTAC_PC_BITS-1:0] pick_pc(input int k);
    if (k >= 8) begin
      return 32'h0000_5000 + (k - 8) * 6;
    end
    return 32'h0000_1000 + k * 6;
  endfunction

  // Reference model, updated at the same edges as the DUT
  always @(posedge clock) begin : model_step
    logic                        was_busy;
    logic                        hit;
    logic                        guess;
    logic [`BTAC_INDEX_BITS-1:0] idx;
    if (!reset) begin
      model_busy     = 1'b1;
      model_index    = '0;
      exp_valid      = 1'b0;
      exp_taken      = 1'b0;
      exp_target     = '0;
      exp_miss       = 1'b0;
      exp_miss_check = 1'b0;
    end else begin
      was_busy = model_busy;
      idx      = index_of(upd_pc);
      hit      = ref_valid[idx] && (ref_tag[idx] == upd_pc);
      guess    = hit && (ref_count[idx] >= 2);
      exp_miss = 1'b0;
      if (upd_valid && !was_busy) begin
        exp_miss = (guess != upd_taken) ||
                   (guess && upd_taken && (ref_target[idx] != upd_target));
      end
      exp_miss_check = upd_valid;
      if (upd_valid) begin
        exp_miss_addr = upd_taken ? upd_target : upd_pc + 32'd4;
      end
      if (was_busy) begin
        ref_valid[model_index]  = 1'b0;
        ref_tag[model_index]    = '0;
        ref_target[model_index] = '0;
        ref_count[model_index]  = `BTAC_COUNT_FLUSH;
        if (model_index == flush_len - 1) begin
          model_busy = 1'b0;
        end else begin
          model_index = model_index + 1'b1;
        end
      end else begin
        if (upd_valid) begin
          if (upd_taken) begin
            ref_valid[idx]  = 1'b1;
            ref_tag[idx]    = upd_pc;
            ref_target[idx] = upd_target;
          end
          if (upd_taken && ref_count[idx] < 3) begin
            ref_count[idx] = ref_count[idx] + 1;
          end else if (!upd_taken && ref_count[idx] > 0) begin
            ref_count[idx] = ref_count[idx] - 1;
          end
        end
        if (clear) begin
          model_busy  = 1'b1;
          model_index = '0;
        end
      end
      // Lookup sees the tables after this edge's writes
      idx        = index_of(look_pc);
      exp_valid  = look_valid;
      exp_taken  = look_valid && !was_busy && ref_valid[idx] &&
                   (ref_tag[idx] == look_pc) && (ref_count[idx] >= 2);
      exp_target = exp_taken ? ref_target[idx] : '0;
    end
  end

  assert property (@(posedge clock) disable iff (!reset) busy == model_busy)
    else value_mismatch("busy", $sampled(model_busy), $sampled(busy));
  assert property (@(posedge clock) disable iff (!reset) pred_valid == exp_valid)
    else value_mismatch("pred_valid", $sampled(exp_valid), $sampled(pred_valid));
  assert property (@(posedge clock) disable iff (!reset) pred_taken == exp_taken)
    else value_mismatch("pred_taken", $sampled(exp_taken), $sampled(pred_taken));
  assert property (@(posedge clock) disable iff (!reset) pred_target == exp_target)
    else value_mismatch("pred_target", $sampled(exp_target), $sampled(pred_target));
  assert property (@(posedge clock) disable iff (!reset) pred_miss == exp_miss)
    else value_mismatch("pred_miss", $sampled(exp_miss), $sampled(pred_miss));
  assert property (@(posedge clock) disable iff (!reset)
    exp_miss_check |-> miss_addr == exp_miss_addr)
    else value_mismatch("miss_addr", $sampled(exp_miss_addr), $sampled(miss_addr));

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      abort_run($sformatf("Timeout: the run did not finish within %0d cycles", max_cycles));
    end
  end

  task automatic drive_cycle(input logic lv, input logic [`BTAC_PC_BITS-1:0] lpc,
                             input logic uv, input logic [`BTAC_PC_BITS-1:0] upc,
                             input logic ut, input logic [`BTAC_PC_BITS-1:0] utgt,
                             input logic clr);
    @(posedge clock);
    #1;
    look_valid = lv;
    look_pc    = lpc;
    upd_valid  = uv;
    upd_pc     = upc;
    upd_taken  = ut;
    upd_target = utgt;
    clear      = clr;
  endtask

  task automatic lookup(input logic [`BTAC_PC_BITS-1:0] pc);
    drive_cycle(1'b1, pc, 1'b0, '0, 1'b0, '0, 1'b0);
  endtask

  task automatic update(input logic [`BTAC_PC_BITS-1:0] pc, input logic taken,
                        input logic [`BTAC_PC_BITS-1:0] target);
    drive_cycle(1'b0, '0, 1'b1, pc, taken, target, 1'b0);
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b0);
  endtask

  task automatic wait_flush_done();
    idle_cycle();
    while (busy) begin
      idle_cycle();
    end
    idle_cycle();
  endtask

  initial begin
    int                       k;
    int unsigned              r;
    logic                     lv;
    logic                     uv;
    logic [`BTAC_PC_BITS-1:0] tgt;
    reset      = 1'b0;
    clear      = 1'b0;
    look_valid = 1'b0;
    look_pc    = '0;
    upd_valid  = 1'b0;
    upd_pc     = '0;
    upd_taken  = 1'b0;
    upd_target = '0;
    lcg_state  = 89361;
    test_name  = "reset";
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b1;

    test_name = "flush";
    lookup(pick_pc(0));
    update(pick_pc(1), 1'b1, 32'h0000_8000);
    drive_cycle(1'b1, pick_pc(1), 1'b1, pick_pc(1), 1'b0, '0, 1'b0);
    drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b1);  // Clear while busy is ignored
    wait_flush_done();

    test_name = "cold lookup";
    for (k = 0; k < 10; k++) begin
      lookup(pick_pc(k));
    end

    test_name = "training";
    update(pick_pc(0), 1'b1, 32'h0000_8040);
    update(pick_pc(0), 1'b1, 32'h0000_8040);
    lookup(pick_pc(0));

    test_name = "mispredict";
    update(pick_pc(0), 1'b1, 32'h0000_80c0);  // New target
    lookup(pick_pc(0));
    update(pick_pc(0), 1'b0, '0);
    update(pick_pc(0), 1'b0, '0);
    update(pick_pc(0), 1'b0, '0);
    lookup(pick_pc(0));

    test_name = "tags and clear";
    update(pick_pc(1), 1'b1, 32'h0000_8080);
    update(pick_pc(1), 1'b1, 32'h0000_8080);
    lookup(pick_pc(9));
    lookup(pick_pc(1));
    drive_cycle(1'b1, pick_pc(1), 1'b0, '0, 1'b0, '0, 1'b1);
    lookup(pick_pc(1));
    update(pick_pc(1), 1'b1, 32'h0000_8080);
    wait_flush_done();
    lookup(pick_pc(1));

    test_name = "random mix";
    for (k = 0; k < random_ops; k++) begin
      r  = next_random();
      lv = r[31];
      uv = r[30];
      if (!lv && !uv) begin
        lv = 1'b1;
      end
      tgt = 32'h0000_8000 + ((r >> 16) % 4) * 32'h40;
      drive_cycle(lv, pick_pc((r >> 18) % 10), uv, pick_pc((r >> 22) % 10),
                  r[29] | r[28], tgt, 1'b0);
    end
    idle_cycle();
    idle_cycle();
    idle_cycle();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- tb/tb_clock.sv
module tb_clock #(
  parameter int half_period = 5
) (
  output logic clock
);

  initial begin
    clock = 1'b0;
  end

  always #half_period clock = ~clock;  // 10-unit period

endmodule

//--- btac/btac.sv
`include "btac_consts.svh"

module btac (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     clear,
  input  logic                     look_valid,
  input  logic [`BTAC_PC_BITS-1:0] look_pc,
  input  logic                     upd_valid,
  input  logic [`BTAC_PC_BITS-1:0] upd_pc,
  input  logic                     upd_taken,
  input  logic [`BTAC_PC_BITS-1:0] upd_target,
  output logic                     busy,
  output logic                     pred_valid,
  output logic                     pred_taken,
  output logic [`BTAC_PC_BITS-1:0] pred_target,
  output logic                     pred_miss,
  output logic [`BTAC_PC_BITS-1:0] miss_addr
);

  logic                        flush_start;
  logic                        flush_last;
  logic [`BTAC_INDEX_BITS-1:0] flush_index;

  logic [`BTAC_INDEX_BITS-1:0] look_index;
  logic [`BTAC_INDEX_BITS-1:0] upd_index;

  logic                        btb_wen;
  logic [`BTAC_INDEX_BITS-1:0] btb_waddr;
  btac_pkg::btb_entry_t        btb_wdata;
  btac_pkg::btb_entry_t        btb_rdata_a;
  btac_pkg::btb_entry_t        btb_rdata_b;

  logic                        bht_wen;
  logic [`BTAC_INDEX_BITS-1:0] bht_waddr;
  btac_pkg::bht_count_t        bht_wdata;
  btac_pkg::bht_count_t        bht_rdata_a;
  btac_pkg::bht_count_t        bht_rdata_b;

  flush_fsm flush_fsm (
    .clock    (clock),
    .reset    (reset),
    .clear    (clear),
    .last     (flush_last),
    .start    (flush_start),
    .flushing (busy)
  );

  index_counter index_counter (
    .clock (clock),
    .reset (reset),
    .start (flush_start),
    .index (flush_index),
    .last  (flush_last)
  );

  btac_ctrl btac_ctrl (
    .clock       (clock),
    .reset       (reset),
    .look_valid  (look_valid),
    .look_pc     (look_pc),
    .upd_valid   (upd_valid),
    .upd_pc      (upd_pc),
    .upd_taken   (upd_taken),
    .upd_target  (upd_target),
    .flushing    (busy),
    .flush_index (flush_index),
    .btb_rdata_a (btb_rdata_a),
    .btb_rdata_b (btb_rdata_b),
    .bht_rdata_a (bht_rdata_a),
    .bht_rdata_b (bht_rdata_b),
    .btb_wen     (btb_wen),
    .btb_waddr   (btb_waddr),
    .btb_wdata   (btb_wdata),
    .bht_wen     (bht_wen),
    .bht_waddr   (bht_waddr),
    .bht_wdata   (bht_wdata),
    .look_index  (look_index),
    .upd_index   (upd_index),
    .pred_valid  (pred_valid),
    .pred_taken  (pred_taken),
    .pred_target (pred_target),
    .pred_miss   (pred_miss),
    .miss_addr   (miss_addr)
  );

  // Branch target buffer
  predictor_table #(
    .entry_type (btac_pkg::btb_entry_t)
  ) btb_table (
    .clock   (clock),
    .wen     (btb_wen),
    .waddr   (btb_waddr),
    .wdata   (btb_wdata),
    .raddr_a (look_index),
    .raddr_b (upd_index),
    .rdata_a (btb_rdata_a),
    .rdata_b (btb_rdata_b)
  );

  // Branch history counters
  predictor_table #(
    .entry_type (btac_pkg::bht_count_t)
  ) bht_table (
    .clock   (clock),
    .wen     (bht_wen),
    .waddr   (bht_waddr),
    .wdata   (bht_wdata),
    .raddr_a (look_index),
    .raddr_b (upd_index),
    .rdata_a (bht_rdata_a),
    .rdata_b (bht_rdata_b)
  );

endmodule

//--- btac/btac_ctrl.sv
`include "btac_consts.svh"

module btac_ctrl (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        look_valid,
  input  logic [`BTAC_PC_BITS-1:0]    look_pc,
  input  logic                        upd_valid,
  input  logic [`BTAC_PC_BITS-1:0]    upd_pc,
  input  logic                        upd_taken,
  input  logic [`BTAC_PC_BITS-1:0]    upd_target,
  input  logic                        flushing,
  input  logic [`BTAC_INDEX_BITS-1:0] flush_index,
  input  btac_pkg::btb_entry_t        btb_rdata_a,
  input  btac_pkg::btb_entry_t        btb_rdata_b,
  input  btac_pkg::bht_count_t        bht_rdata_a,
  input  btac_pkg::bht_count_t        bht_rdata_b,
  output logic                        btb_wen,
  output logic [`BTAC_INDEX_BITS-1:0] btb_waddr,
  output btac_pkg::btb_entry_t        btb_wdata,
  output logic                        bht_wen,
  output logic [`BTAC_INDEX_BITS-1:0] bht_waddr,
  output btac_pkg::bht_count_t        bht_wdata,
  output logic [`BTAC_INDEX_BITS-1:0] look_index,
  output logic [`BTAC_INDEX_BITS-1:0] upd_index,
  output logic                        pred_valid,
  output logic                        pred_taken,
  output logic [`BTAC_PC_BITS-1:0]    pred_target,
  output logic                        pred_miss,
  output logic [`BTAC_PC_BITS-1:0]    miss_addr
);

  logic [`BTAC_PC_BITS-1:0] look_pc_q;
  logic                     look_flush_q;
  logic                     look_hit;
  logic                     upd_accept;
  logic                     upd_hit;
  logic                     upd_pred_taken;
  logic                     upd_wrong;
  btac_pkg::bht_count_t     upd_count;

  // Lookup request, index and PC are held for the read after the edge
  always_ff @(posedge clock) begin
    if (!reset) begin
      pred_valid   <= 1'b0;
      look_flush_q <= 1'b0;
    end else begin
      pred_valid   <= look_valid;
      look_flush_q <= flushing;
    end
  end

  always_ff @(posedge clock) begin
    if (look_valid) begin
      look_index <= look_pc[`BTAC_INDEX_BITS:1];
      look_pc_q  <= look_pc;
    end
  end

  // Prediction from port A
  assign look_hit = btb_rdata_a.valid && (btb_rdata_a.tag == look_pc_q);

  assign pred_taken  = pred_valid && !look_flush_q && look_hit && bht_rdata_a[1];
  assign pred_target = pred_taken ? btb_rdata_a.target : '0;

  // Update side, port B shows the entry as it was before this write
  assign upd_index  = upd_pc[`BTAC_INDEX_BITS:1];
  assign upd_accept = upd_valid && !flushing;  // Updates dropped while the tables are walked

  assign upd_hit        = btb_rdata_b.valid && (btb_rdata_b.tag == upd_pc);
  assign upd_pred_taken = upd_hit && bht_rdata_b[1];

  always_comb begin
    upd_wrong = (upd_pred_taken != upd_taken);
    if (upd_pred_taken && upd_taken && (btb_rdata_b.target != upd_target)) begin
      upd_wrong = 1'b1;  // Right direction, stale target
    end
  end

  // Saturating counter step
  always_comb begin
    upd_count = bht_rdata_b;
    if (upd_taken) begin
      if (bht_rdata_b != 2'd3) begin
        upd_count = bht_rdata_b + 2'd1;
      end
    end else if (bht_rdata_b != 2'd0) begin
      upd_count = bht_rdata_b - 2'd1;
    end
  end

  // Write port steering, a flush takes both tables over
  always_comb begin
    if (flushing) begin
      btb_wen          = 1'b1;
      btb_waddr        = flush_index;
      btb_wdata        = '0;
      bht_wen          = 1'b1;
      bht_waddr        = flush_index;
      bht_wdata        = `BTAC_COUNT_FLUSH;
    end else begin
      btb_wen          = upd_valid && upd_taken;  // Only taken branches allocate
      btb_waddr        = upd_index;
      btb_wdata.valid  = 1'b1;
      btb_wdata.tag    = upd_pc;
      btb_wdata.target = upd_target;
      bht_wen          = upd_valid;
      bht_waddr        = upd_index;
      bht_wdata        = upd_count;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      pred_miss <= 1'b0;
    end else begin
      pred_miss <= upd_accept && upd_wrong;
    end
  end

  // Redirect address for the fetch unit
  always_ff @(posedge clock) begin
    if (upd_valid) begin
      miss_addr <= upd_taken ? upd_target : upd_pc + `BTAC_PC_BITS'd4;
    end
  end

  // An update seen during a flush must never report a miss
  assert property (@(posedge clock) disable iff (!reset) $past(flushing) |-> !pred_miss)
    else $error("btac_ctrl: pred_miss after a flush cycle");

endmodule

//--- logic/index_counter.sv
`include "btac_consts.svh"

module index_counter (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        start,
  output logic [`BTAC_INDEX_BITS-1:0] index,
  output logic                        last
);

  logic active;

  assign last = active && (index == '1);

  always_ff @(posedge clock) begin
    if (!reset) begin
      index  <= '0;
      active <= 1'b1;  // Reset itself begins a walk from entry 0
    end else if (start) begin
      index  <= '0;
      active <= 1'b1;
    end else if (active) begin
      if (last) begin
        active <= 1'b0;  // Hold at the top entry until the next start
      end else begin
        index <= index + 1'b1;
      end
    end
  end

endmodule

//--- logic/flush_fsm.sv
module flush_fsm (
  input  logic clock,
  input  logic reset,
  input  logic clear,
  input  logic last,
  output logic start,
  output logic flushing
);

  btac_pkg::flush_state_t state;

  // A clear is only taken while idle
  assign start    = (state == btac_pkg::flush_idle) && clear;
  assign flushing = (state == btac_pkg::flush_run);

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= btac_pkg::flush_run;  // Tables are walked clean after reset
    end else begin
      case (state)
        btac_pkg::flush_idle: begin
          if (clear) begin
            state <= btac_pkg::flush_run;
          end
        end
        btac_pkg::flush_run: begin
          if (last) begin
            state <= btac_pkg::flush_idle;  // Top entry written this cycle
          end
        end
        default: begin
          state <= btac_pkg::flush_idle;
        end
      endcase
    end
  end

  // A start opens a run whose walk begins again at entry 0
  assert property (@(posedge clock) disable iff (!reset)
    start |=> (state == btac_pkg::flush_run) && !last)
    else $error("flush_fsm: start did not open a fresh walk");

endmodule

//--- logic/predictor_table.sv
`include "btac_consts.svh"

module predictor_table #(
  parameter type entry_type = logic [1:0]
) (
  input  logic                        clock,
  input  logic                        wen,
  input  logic [`BTAC_INDEX_BITS-1:0] waddr,
  input  entry_type                   wdata,
  input  logic [`BTAC_INDEX_BITS-1:0] raddr_a,
  input  logic [`BTAC_INDEX_BITS-1:0] raddr_b,
  output entry_type                   rdata_a,
  output entry_type                   rdata_b
);

  localparam int depth = 1 << `BTAC_INDEX_BITS;

  entry_type table_mem [0:depth-1];

  // Both read ports are combinational
  assign rdata_a = table_mem[raddr_a];  // Lookup side
  assign rdata_b = table_mem[raddr_b];  // Update side

  always_ff @(posedge clock) begin
    if (wen) begin
      table_mem[waddr] <= wdata;
    end
  end

  // An unknown write address would corrupt an arbitrary entry
  assert property (@(posedge clock) wen |-> !$isunknown(waddr))
    else $error("predictor_table: write with unknown address");

endmodule

//--- common/btac_pkg.sv
`include "btac_consts.svh"

package btac_pkg;

  // One BTB line: full branch PC as tag plus the taken target
  typedef struct packed {
    logic                     valid;
    logic [`BTAC_PC_BITS-1:0] tag;
    logic [`BTAC_PC_BITS-1:0] target;
  } btb_entry_t;

  // 2-bit saturating counter, 2 and 3 mean taken
  typedef logic [1:0] bht_count_t;

  typedef enum logic {
    flush_idle,
    flush_run
  } flush_state_t;

endpackage

//--- common/btac_consts.svh
`ifndef BTAC_CONSTS_SVH
`define BTAC_CONSTS_SVH

// Index bits for both tables, 64 entries each
`define BTAC_INDEX_BITS 6

// Fetch and branch address width
`define BTAC_PC_BITS 32

// Counter value written by a flush (weakly not taken)
`define BTAC_COUNT_FLUSH 2'd1

`endif
